// File: logic/telemetry_pkg.sv
package telemetry_pkg;

	// measured value widths
	localparam int RPM_WIDTH  = 10; // wheel speed, rpm
	localparam int DIST_WIDTH = 7;  // wall distance, cm

	// frame layout
	localparam int WORD_WIDTH     = 32; // one fifo word, one frame field
	localparam int NUM_CHANNELS   = 3;  // left rpm, right rpm, distance
	localparam int BYTES_PER_WORD = WORD_WIDTH / 8;

	// one sample as it enters the capture stage
	typedef struct packed {
		logic [RPM_WIDTH-1:0]  rpm_l;
		logic [RPM_WIDTH-1:0]  rpm_r;
		logic [DIST_WIDTH-1:0] dist_cm;
	} telemetry_sample_t;

	typedef logic [WORD_WIDTH-1:0] chan_word_t; // zero-extended channel value

	// ascending range so lane 0 (left rpm) lands in the top bits, i.e. goes out first
	typedef chan_word_t [0:NUM_CHANNELS-1] chan_words_t;

	typedef enum logic [1:0] {
		FRAME_IDLE,
		FRAME_LOAD,      // latch heads, pop
		FRAME_SEND,      // start pulse for one byte
		FRAME_WAIT_DONE  // byte on the wire
	} frame_state_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

endpackage

// File: logic/sample_tick.sv
`timescale 1ns/1ps

module sample_tick #(
	parameter int SAMPLE_DIVISOR = 600 // clk cycles per tick
) (
	input  logic clk,
	input  logic reset,
	output logic o_tick
);

	localparam int CNT_W = (SAMPLE_DIVISOR > 1) ? $clog2(SAMPLE_DIVISOR) : 1;
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(SAMPLE_DIVISOR - 1);

	logic [CNT_W-1:0] cnt_q; // counts down to zero

	// first tick lands SAMPLE_DIVISOR edges after reset release
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cnt_q  <= RELOAD;
			o_tick <= 1'b0;
		end else if (cnt_q == '0) begin
			cnt_q  <= RELOAD; // wrap and fire
			o_tick <= 1'b1;
		end else begin
			cnt_q  <= cnt_q - 1'b1;
			o_tick <= 1'b0;   // one cycle wide only
		end
	end

endmodule

// File: logic/telemetry_capture.sv
`timescale 1ns/1ps

module telemetry_capture import telemetry_pkg::*; (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    i_tick,
	input  logic                    i_motor_en,  // logging permitted
	input  telemetry_sample_t       i_sample,
	input  logic [NUM_CHANNELS-1:0] i_full,      // per-lane full flags
	output logic                    o_wr_en,     // shared by all lanes
	output chan_words_t             o_wr_words
);

	logic tick_q;    // tick delayed one cycle
	logic tick_fall; // trailing edge of the tick
	logic any_full;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tick_q <= 1'b0;
		end else begin
			tick_q <= i_tick;
		end
	end

	assign tick_fall = tick_q & ~i_tick;

	// one full lane drops the whole sample, lanes stay aligned
	assign any_full = |i_full;

	assign o_wr_en = tick_fall & i_motor_en & ~any_full;

	// zero-extend each field, lane order matches frame order
	assign o_wr_words[0] = chan_word_t'(i_sample.rpm_l);   // left wheel
	assign o_wr_words[1] = chan_word_t'(i_sample.rpm_r);   // right wheel
	assign o_wr_words[2] = chan_word_t'(i_sample.dist_cm); // wall distance

endmodule

// File: logic/channel_fifo.sv
`timescale 1ns/1ps

module channel_fifo import telemetry_pkg::*; #(
	parameter int FIFO_DEPTH_POW2 = 2 // depth = 2**FIFO_DEPTH_POW2
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       i_wr_en,
	input  logic       i_rd_en, // pop, head leaves this cycle
	input  chan_word_t i_din,
	output chan_word_t o_dout,  // head word, valid while not empty
	output logic       o_empty,
	output logic       o_full
);

	localparam int DEPTH = 2 ** FIFO_DEPTH_POW2;

	chan_word_t mem [DEPTH];

	logic [FIFO_DEPTH_POW2-1:0] wr_ptr_q;
	logic [FIFO_DEPTH_POW2-1:0] rd_ptr_q;
	logic                       wr_wrap_q; // toggles each pass round the buffer
	logic                       rd_wrap_q;
	logic                       ptr_match;

	assign ptr_match = (wr_ptr_q == rd_ptr_q);
	assign o_empty   = ptr_match & (wr_wrap_q == rd_wrap_q);
	assign o_full    = ptr_match & (wr_wrap_q != rd_wrap_q); // same slot, one lap ahead

	assign o_dout = mem[rd_ptr_q]; // fall-through head

	always_ff @(posedge clk) begin
		if (i_wr_en) begin
			mem[wr_ptr_q] <= i_din;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr_q  <= '0;
			rd_ptr_q  <= '0;
			wr_wrap_q <= 1'b0;
			rd_wrap_q <= 1'b0;
		end else begin
			if (i_wr_en) begin
				{wr_wrap_q, wr_ptr_q} <= {wr_wrap_q, wr_ptr_q} + 1'b1; // carry into wrap
			end
			if (i_rd_en) begin
				{rd_wrap_q, rd_ptr_q} <= {rd_wrap_q, rd_ptr_q} + 1'b1;
			end
		end
	end

	// capture stage must hold off writes on a full lane
	a_no_write_full : assert property (@(posedge clk) disable iff (reset) i_wr_en |-> !o_full)
		else $error("channel_fifo: write while full");

	// frame sequencer only pops after checking every lane
	a_no_pop_empty : assert property (@(posedge clk) disable iff (reset) i_rd_en |-> !o_empty)
		else $error("channel_fifo: pop while empty");

endmodule

// File: logic/uart_frame_fsm.sv
`timescale 1ns/1ps

module uart_frame_fsm import telemetry_pkg::*; (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    i_uart_en, // sending permitted
	input  logic                    i_tx_done,
	input  chan_words_t             i_words,   // fifo heads
	input  logic [NUM_CHANNELS-1:0] i_empty,
	output logic                    o_rd_en,   // shared pop
	output logic                    o_start_tx,
	output logic [7:0]              o_tx_byte
);

	localparam int FRAME_BYTES = NUM_CHANNELS * BYTES_PER_WORD; // 12
	localparam int FRAME_BITS  = NUM_CHANNELS * WORD_WIDTH;
	localparam int CNT_W       = $clog2(FRAME_BYTES);
	localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(FRAME_BYTES - 1);

	frame_state_t          state_q;
	logic [FRAME_BITS-1:0] shift_q;     // whole frame, next byte on top
	logic [CNT_W-1:0]      byte_cnt_q;
	logic                  in_flight_q; // start seen, done not yet

	assign o_rd_en    = (state_q == FRAME_LOAD);
	assign o_start_tx = (state_q == FRAME_SEND);
	assign o_tx_byte  = shift_q[FRAME_BITS-1 -: 8]; // msb byte first

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state_q    <= FRAME_IDLE;
			byte_cnt_q <= '0;
		end else begin
			case (state_q)
				FRAME_IDLE: begin
					// every lane must hold a word, frames stay whole
					if (i_uart_en && !(|i_empty)) begin
						state_q <= FRAME_LOAD;
					end
				end
				FRAME_LOAD: begin
					byte_cnt_q <= '0;
					state_q    <= FRAME_SEND;
				end
				FRAME_SEND: state_q <= FRAME_WAIT_DONE;
				FRAME_WAIT_DONE: begin
					if (i_tx_done) begin
						if (byte_cnt_q == LAST_BYTE) begin
							state_q <= FRAME_IDLE; // uart enable only matters here
						end else begin
							byte_cnt_q <= byte_cnt_q + 1'b1;
							state_q    <= FRAME_SEND;
						end
					end
				end
				default: state_q <= FRAME_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == FRAME_LOAD) begin
			shift_q <= i_words; // lane 0 lands in the top word
		end else if (state_q == FRAME_WAIT_DONE && i_tx_done) begin
			shift_q <= shift_q << 8;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			in_flight_q <= 1'b0;
		end else if (o_start_tx) begin
			in_flight_q <= 1'b1;
		end else if (i_tx_done) begin
			in_flight_q <= 1'b0;
		end
	end

	// one byte at a time on the transmitter
	a_start_idle : assert property (@(posedge clk) disable iff (reset) o_start_tx |-> !in_flight_q)
		else $error("uart_frame_fsm: start while byte in flight");

	// transmitter answers only bytes it was given
	a_done_owed : assert property (@(posedge clk) disable iff (reset) i_tx_done |-> in_flight_q)
		else $error("uart_frame_fsm: done without start");

endmodule

// File: logic/uart_tx.sv
`timescale 1ns/1ps

module uart_tx import telemetry_pkg::*; #(
	parameter int CLKS_PER_BIT = 4 // clk cycles per serial bit
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       i_start, // one-cycle request
	input  logic [7:0] i_din,
	output logic       o_serial_tx,
	output logic       o_done   // pulse after stop bit
);

	localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS_PER_BIT - 1);

	tx_state_t        state_q;
	logic [CNT_W-1:0] clk_cnt_q; // position within a bit
	logic [2:0]       bit_idx_q;
	logic [7:0]       shift_q;   // lsb goes out next
	logic             bit_end;

	assign bit_end = (clk_cnt_q == BIT_END);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state_q   <= TX_IDLE;
			clk_cnt_q <= '0;
			bit_idx_q <= '0;
			o_done    <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (state_q == TX_IDLE || bit_end) begin
				clk_cnt_q <= '0;
			end else begin
				clk_cnt_q <= clk_cnt_q + 1'b1;
			end
			case (state_q)
				TX_IDLE: begin
					bit_idx_q <= '0;
					if (i_start) state_q <= TX_START;
				end
				TX_START: if (bit_end) state_q <= TX_DATA;
				TX_DATA: begin
					if (bit_end) begin
						bit_idx_q <= bit_idx_q + 1'b1;
						if (bit_idx_q == 3'd7) state_q <= TX_STOP; // eighth bit sent
					end
				end
				TX_STOP: begin
					if (bit_end) begin
						state_q <= TX_IDLE;
						o_done  <= 1'b1;
					end
				end
				default: state_q <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == TX_IDLE && i_start) begin
			shift_q <= i_din;
		end else if (state_q == TX_DATA && bit_end) begin
			shift_q <= shift_q >> 1;
		end
	end

	// line idles high
	always_comb begin
		case (state_q)
			TX_START: o_serial_tx = 1'b0;
			TX_DATA:  o_serial_tx = shift_q[0];
			default:  o_serial_tx = 1'b1; // idle and stop bit
		endcase
	end

endmodule

// File: logic/telemetry_top.sv
`timescale 1ns/1ps

module telemetry_top import telemetry_pkg::*; #(
	parameter int SAMPLE_DIVISOR  = 600, // must exceed one frame time
	parameter int FIFO_DEPTH_POW2 = 2,
	parameter int CLKS_PER_BIT    = 4
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [RPM_WIDTH-1:0]  i_rpm_l,
	input  logic [RPM_WIDTH-1:0]  i_rpm_r,
	input  logic [DIST_WIDTH-1:0] i_dist_cm,
	input  logic                  i_motor_en,
	input  logic                  i_uart_en,
	output logic                  o_serial_tx
);

	telemetry_sample_t       sample;
	logic                    tick;
	logic                    wr_en;
	chan_words_t             wr_words;
	chan_words_t             rd_words;
	logic [NUM_CHANNELS-1:0] full;
	logic [NUM_CHANNELS-1:0] empty;
	logic                    rd_en;
	logic                    start_tx;
	logic [7:0]              tx_byte;
	logic                    tx_done;

	assign sample = '{rpm_l: i_rpm_l, rpm_r: i_rpm_r, dist_cm: i_dist_cm};

	sample_tick #(.SAMPLE_DIVISOR(SAMPLE_DIVISOR)) u_tick (
		.clk   (clk),
		.reset (reset),
		.o_tick(tick)
	);

	telemetry_capture u_capture (
		.clk       (clk),
		.reset     (reset),
		.i_tick    (tick),
		.i_motor_en(i_motor_en),
		.i_sample  (sample),
		.i_full    (full),
		.o_wr_en   (wr_en),
		.o_wr_words(wr_words)
	);

	// one fifo per channel, common write and pop strobes
	for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_chan
		channel_fifo #(.FIFO_DEPTH_POW2(FIFO_DEPTH_POW2)) u_fifo (
			.clk    (clk),
			.reset  (reset),
			.i_wr_en(wr_en),
			.i_rd_en(rd_en),
			.i_din  (wr_words[ch]),
			.o_dout (rd_words[ch]),
			.o_empty(empty[ch]),
			.o_full (full[ch])
		);
	end

	uart_frame_fsm u_frame (
		.clk       (clk),
		.reset     (reset),
		.i_uart_en (i_uart_en),
		.i_tx_done (tx_done),
		.i_words   (rd_words),
		.i_empty   (empty),
		.o_rd_en   (rd_en),
		.o_start_tx(start_tx),
		.o_tx_byte (tx_byte)
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
		.clk        (clk),
		.reset      (reset),
		.i_start    (start_tx),
		.i_din      (tx_byte),
		.o_serial_tx(o_serial_tx),
		.o_done     (tx_done)
	);

endmodule

// File: test/telemetry_checker.sv
`timescale 1ns/1ps

module telemetry_checker import telemetry_pkg::*; #(
	parameter int SAMPLE_DIVISOR = 600,
	parameter int FIFO_DEPTH     = 4,
	parameter int CLKS_PER_BIT   = 4
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [RPM_WIDTH-1:0]  i_rpm_l,
	input  logic [RPM_WIDTH-1:0]  i_rpm_r,
	input  logic [DIST_WIDTH-1:0] i_dist_cm,
	input  logic                  i_motor_en,
	input  logic                  i_uart_en,
	input  logic                  i_serial_tx,
	output int                    o_value_errs,
	output int                    o_proto_errs,
	output int                    o_pending,   // accepted, frame not finished
	output logic                  o_idle       // no frame on the wire
);

	localparam int FRAME_BYTES = NUM_CHANNELS * BYTES_PER_WORD;
	localparam int FRAME_BITS  = NUM_CHANNELS * WORD_WIDTH;
	localparam int HALF_BIT    = CLKS_PER_BIT / 2;

	telemetry_sample_t     exp_q [$]; // what the fifos should hold
	telemetry_sample_t     cur;       // sample of the frame in flight
	telemetry_sample_t     seen;
	logic                  cur_valid;
	int                    edges;      // clk edges since reset release
	int                    uart_quiet; // edges since uart enable last high
	logic                  in_byte;
	int                    bit_time;   // edges since start bit began
	int                    bit_no;
	int                    byte_idx;
	logic [7:0]            rx_byte;
	logic [FRAME_BITS-1:0] rx_frame;

	// each field zero-extended, left field sent first
	task automatic check_frame();
		logic [WORD_WIDTH-1:0] exp_w;
		logic [WORD_WIDTH-1:0] got_w;
		int ch;
		for (ch = 0; ch < NUM_CHANNELS; ch++) begin
			case (ch)
				0: exp_w = {{(WORD_WIDTH-RPM_WIDTH){1'b0}}, cur.rpm_l};
				1: exp_w = {{(WORD_WIDTH-RPM_WIDTH){1'b0}}, cur.rpm_r};
				default: exp_w = {{(WORD_WIDTH-DIST_WIDTH){1'b0}}, cur.dist_cm};
			endcase
			got_w = rx_frame[(NUM_CHANNELS-ch)*WORD_WIDTH-1 -: WORD_WIDTH];
			if (got_w !== exp_w) begin
				$display("Fail at %0t: field %0d is %0h, expected %0h", $time, ch, got_w, exp_w);
				o_value_errs++;
			end
		end
	endtask

	initial begin
		o_value_errs = 0;
		o_proto_errs = 0;
		o_pending    = 0;
		o_idle       = 1'b1;
	end

	always @(posedge clk) begin
		if (reset) begin
			edges      = 0;
			uart_quiet = 1000;
			in_byte    = 1'b0;
			byte_idx   = 0;
			cur_valid  = 1'b0;
			exp_q.delete();
			if (i_serial_tx !== 1'b1) begin
				$display("Fail at %0t: serial line not high during reset", $time);
				o_value_errs++;
			end
		end else begin
			edges++;
			if (i_uart_en) uart_quiet = 0;
			else if (uart_quiet < 1000) uart_quiet++;
			// serial decode, sampled mid-bit
			if (!in_byte) begin
				if (i_serial_tx === 1'b0) begin
					in_byte  = 1'b1;
					bit_time = 0;
					if (byte_idx == 0) begin // new frame
						if (uart_quiet > 4) begin
							$display("frame began at %0t while uart enable was low", $time);
							o_proto_errs++;
						end
						if (exp_q.size() == 0) begin
							$display("frame at %0t carries no captured sample", $time);
							o_proto_errs++;
							cur_valid = 1'b0;
						end else begin
							cur       = exp_q.pop_front();
							cur_valid = 1'b1;
						end
					end
				end
			end else begin
				bit_time++;
				if (bit_time % CLKS_PER_BIT == HALF_BIT) begin
					bit_no = bit_time / CLKS_PER_BIT;
					if (bit_no == 0 && i_serial_tx !== 1'b0) begin
						$display("start bit too short at %0t", $time);
						o_proto_errs++;
					end else if (bit_no >= 1 && bit_no <= 8) begin
						rx_byte[bit_no-1] = i_serial_tx; // lsb first
					end else if (bit_no == 9) begin
						if (i_serial_tx !== 1'b1) begin
							$display("stop bit missing at %0t in byte %0d", $time, byte_idx);
							o_proto_errs++;
						end
						in_byte  = 1'b0;
						rx_frame = {rx_frame[FRAME_BITS-9:0], rx_byte};
						byte_idx++;
						if (byte_idx == FRAME_BYTES) begin
							if (cur_valid) check_frame();
							byte_idx  = 0;
							cur_valid = 1'b0;
						end
					end
				end
			end
			// tick after the D-th edge, write two edges later
			if (edges >= SAMPLE_DIVISOR + 2 && (edges - 2) % SAMPLE_DIVISOR == 0 && i_motor_en) begin
				seen.rpm_l   = i_rpm_l;
				seen.rpm_r   = i_rpm_r;
				seen.dist_cm = i_dist_cm;
				if (exp_q.size() < FIFO_DEPTH) exp_q.push_back(seen); // else dropped whole
			end
		end
		o_pending = exp_q.size() + (cur_valid ? 1 : 0);
		o_idle    = !in_byte && byte_idx == 0;
	end

endmodule

// File: test/tb_telemetry.sv
`timescale 1ns/1ps

module tb_telemetry import telemetry_pkg::*; ();

	localparam int SAMPLE_DIVISOR  = 600;
	localparam int FIFO_DEPTH_POW2 = 2;
	localparam int CLKS_PER_BIT    = 4;
	localparam int NUM_ROWS        = 20;
	localparam int DRAIN_LIMIT     = 1500; // edges to wait for the last frame

	typedef struct packed {
		logic [RPM_WIDTH-1:0]  rpm_l;
		logic [RPM_WIDTH-1:0]  rpm_r;
		logic [DIST_WIDTH-1:0] dist_cm;
		logic                  motor_en;
		logic                  uart_en;
		logic                  rnd;  // draw the three values at random
		logic [3:0]            hold; // in ticks
	} stim_row_t;

	logic                  clk;
	logic                  reset;
	logic [RPM_WIDTH-1:0]  rpm_l;
	logic [RPM_WIDTH-1:0]  rpm_r;
	logic [DIST_WIDTH-1:0] dist_cm;
	logic                  motor_en;
	logic                  uart_en;
	logic                  serial_tx;
	int                    value_errs;
	int                    proto_errs;
	int                    pending;
	logic                  idle;
	stim_row_t             rows [NUM_ROWS];
	int                    seed;
	int                    cycles;
	int                    cycle_limit;

	telemetry_top #(
		.SAMPLE_DIVISOR (SAMPLE_DIVISOR),
		.FIFO_DEPTH_POW2(FIFO_DEPTH_POW2),
		.CLKS_PER_BIT   (CLKS_PER_BIT)
	) dut0 (
		.clk        (clk),
		.reset      (reset),
		.i_rpm_l    (rpm_l),
		.i_rpm_r    (rpm_r),
		.i_dist_cm  (dist_cm),
		.i_motor_en (motor_en),
		.i_uart_en  (uart_en),
		.o_serial_tx(serial_tx)
	);

	telemetry_checker #(
		.SAMPLE_DIVISOR(SAMPLE_DIVISOR),
		.FIFO_DEPTH    (2 ** FIFO_DEPTH_POW2),
		.CLKS_PER_BIT  (CLKS_PER_BIT)
	) chk0 (
		.clk         (clk),
		.reset       (reset),
		.i_rpm_l     (rpm_l),
		.i_rpm_r     (rpm_r),
		.i_dist_cm   (dist_cm),
		.i_motor_en  (motor_en),
		.i_uart_en   (uart_en),
		.i_serial_tx (serial_tx),
		.o_value_errs(value_errs),
		.o_proto_errs(proto_errs),
		.o_pending   (pending),
		.o_idle      (idle)
	);

	function automatic stim_row_t make_row(input logic [RPM_WIDTH-1:0] l,
		input logic [RPM_WIDTH-1:0] r, input logic [DIST_WIDTH-1:0] d,
		input logic m, input logic u, input logic rnd, input logic [3:0] hold);
		stim_row_t row;
		row = '{rpm_l: l, rpm_r: r, dist_cm: d, motor_en: m, uart_en: u, rnd: rnd, hold: hold};
		return row;
	endfunction

	task automatic fill_table();
		int i;
		rows[0]  = make_row(10'd0,   10'd0,   7'd0,  1'b0, 1'b0, 1'b0, 4'd2); // line stays idle
		rows[1]  = make_row(10'd123, 10'd456, 7'd42, 1'b1, 1'b1, 1'b0, 4'd3);
		rows[2]  = make_row(10'h3ff, 10'h000, 7'h7f, 1'b1, 1'b1, 1'b0, 4'd1); // range edges
		rows[3]  = make_row(10'd999, 10'd998, 7'd99, 1'b0, 1'b1, 1'b0, 4'd2); // motor off
		// six samples into a depth-4 fifo, last two dropped
		for (i = 0; i < 6; i++) begin
			rows[4+i] = make_row(10'(101 + i), 10'(201 + i), 7'(11 + i), 1'b1, 1'b0, 1'b0, 4'd1);
		end
		rows[10] = make_row(10'd0,   10'd0,   7'd0,  1'b0, 1'b1, 1'b0, 4'd5); // drain backlog
		rows[11] = make_row(10'd700, 10'd35,  7'd64, 1'b1, 1'b1, 1'b0, 4'd1);
		rows[12] = make_row(10'd0,   10'd0,   7'd0,  1'b0, 1'b0, 1'b0, 4'd2); // uart off mid frame
		for (i = 13; i < 19; i++) begin
			rows[i] = make_row(10'd0, 10'd0, 7'd0, 1'b1, 1'b1, 1'b1, 4'd1);
		end
		rows[19] = make_row(10'd0,   10'd0,   7'd0,  1'b0, 1'b1, 1'b0, 4'd2);
	endtask

	task automatic apply_row(input stim_row_t row);
		int rnd_val;
		motor_en = row.motor_en;
		uart_en  = row.uart_en;
		if (row.rnd) begin
			rnd_val = $random(seed);
			rpm_l   = rnd_val[RPM_WIDTH-1:0];
			rnd_val = $random(seed);
			rpm_r   = rnd_val[RPM_WIDTH-1:0];
			rnd_val = $random(seed);
			dist_cm = rnd_val[DIST_WIDTH-1:0];
		end else begin
			rpm_l   = row.rpm_l;
			rpm_r   = row.rpm_r;
			dist_cm = row.dist_cm;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// watchdog
	always @(posedge clk) begin
		if (reset) begin
			cycles = 0;
		end else begin
			cycles++;
			if (cycle_limit > 0 && cycles >= cycle_limit) begin
				$display("timeout after %0d cycles, frames never finished draining", cycles);
				$display("Regression failed");
				$finish;
			end
		end
	end

	initial begin
		int total_ticks;
		int r;
		int wait_cnt;
		reset       = 1'b1;
		rpm_l       = '0;
		rpm_r       = '0;
		dist_cm     = '0;
		motor_en    = 1'b0;
		uart_en     = 1'b0;
		seed        = 32'hbb2a;
		cycles      = 0;
		cycle_limit = 0;
		fill_table();
		total_ticks = 0;
		for (r = 0; r < NUM_ROWS; r++) total_ticks += int'(rows[r].hold);
		cycle_limit = total_ticks * SAMPLE_DIVISOR + 2000;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		repeat (SAMPLE_DIVISOR / 2) @(negedge clk); // row edges sit between writes
		for (r = 0; r < NUM_ROWS; r++) begin
			apply_row(rows[r]);
			repeat (int'(rows[r].hold) * SAMPLE_DIVISOR) @(negedge clk);
		end
		wait_cnt = 0;
		while ((pending != 0 || !idle) && wait_cnt < DRAIN_LIMIT) begin
			@(negedge clk);
			wait_cnt++;
		end
		if (pending != 0) $display("%0d captured samples were never sent", pending);
		$display("errors: value %0d, protocol %0d, unsent %0d", value_errs, proto_errs, pending);
		if (value_errs == 0 && proto_errs == 0 && pending == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: vlog.f
logic/telemetry_pkg.sv
logic/sample_tick.sv
logic/telemetry_capture.sv
logic/channel_fifo.sv
logic/uart_frame_fsm.sv
logic/uart_tx.sv
logic/telemetry_top.sv
test/telemetry_checker.sv
test/tb_telemetry.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the telemetry regression with verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module tb_telemetry -f vlog.f; then
	echo "verilator build failed"
	exit 1
fi

if ! sim_out=$(./obj_dir/Vtb_telemetry); then
	echo "$sim_out"
	echo "simulation exited with an error"
	exit 1
fi
echo "$sim_out"

if grep -qx "Regression passed" <<< "$sim_out"; then
	exit 0
fi
exit 1
